// File: verilog/rdma_pkg.sv
// RDMA command types, queue pair count and payload length limit
package rdma_pkg;

  // Queue pair number as carried in commands and headers
  typedef logic [7:0] qpn_t;

  // Packet sequence number, wraps modulo 65536
  typedef logic [15:0] psn_t;

  // Virtual word address in local or remote memory
  typedef logic [31:0] vaddr_t;

  // Payload length in 32-bit words
  typedef logic [7:0] len_t;

  // Queue pairs held in the PSN table
  localparam int N_QP = 4;

  // Table index width, low bits of the QP number
  localparam int QP_IDX_BITS = 2;

  // Largest payload per frame, in words
  localparam int MAX_LEN = 16;

endpackage

// File: verilog/roce_pkt_pkg.sv
// Network word type and frame layout constants
package roce_pkt_pkg;

  // One word of the network stream
  typedef logic [31:0] word_t;

  // Header words ahead of the payload: QP/PSN/length, then remote address
  localparam int HDR_WORDS = 2;

  // Receive frame buffer, header and payload only
  localparam int FRAME_BUF_DEPTH = 32;

  // Buffer pointer width
  localparam int BUF_AW = $clog2(FRAME_BUF_DEPTH);

endpackage

// File: verilog/qp_psn_table.sv
// Per-QP transmit PSN and expected receive PSN table with lookup ports
`timescale 1ns/1ns

module qp_psn_table (
  input  logic           nclk,
  input  logic           nresetn,
  input  logic           cfg_valid,
  input  rdma_pkg::qpn_t cfg_qpn,
  input  rdma_pkg::psn_t cfg_psn,
  input  rdma_pkg::qpn_t tx_qpn,
  output rdma_pkg::psn_t tx_psn,
  input  logic           tx_advance,
  input  rdma_pkg::qpn_t rx_qpn,
  output rdma_pkg::psn_t rx_epsn,
  input  logic           rx_advance
);

  rdma_pkg::psn_t tx_psn_q [rdma_pkg::N_QP];
  rdma_pkg::psn_t rx_epsn_q [rdma_pkg::N_QP];

  logic [rdma_pkg::QP_IDX_BITS-1:0] cfg_idx;
  logic [rdma_pkg::QP_IDX_BITS-1:0] tx_idx;
  logic [rdma_pkg::QP_IDX_BITS-1:0] rx_idx;

  assign cfg_idx = cfg_qpn[rdma_pkg::QP_IDX_BITS-1:0];
  assign tx_idx  = tx_qpn[rdma_pkg::QP_IDX_BITS-1:0];
  assign rx_idx  = rx_qpn[rdma_pkg::QP_IDX_BITS-1:0];

  // Combinational lookups for both engines
  assign tx_psn  = tx_psn_q[tx_idx];
  assign rx_epsn = rx_epsn_q[rx_idx];

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      for (int i = 0; i < rdma_pkg::N_QP; i++) begin
        tx_psn_q[i]  <= '0;
        rx_epsn_q[i] <= '0;
      end
    end else begin
      if (tx_advance) begin
        tx_psn_q[tx_idx] <= tx_psn_q[tx_idx] + rdma_pkg::psn_t'(1);
      end
      if (rx_advance) begin
        rx_epsn_q[rx_idx] <= rx_epsn_q[rx_idx] + rdma_pkg::psn_t'(1);
      end
      // Config write sets both directions to the same start PSN
      if (cfg_valid) begin
        tx_psn_q[cfg_idx]  <= cfg_psn;
        rx_epsn_q[cfg_idx] <= cfg_psn;
      end
    end
  end

  // An engine must not advance a QP that is being reconfigured
  assert property (@(posedge nclk) disable iff (!nresetn)
    cfg_valid |-> !(tx_advance && tx_idx == cfg_idx) && !(rx_advance && rx_idx == cfg_idx))
    else $error("qp_psn_table: PSN advance collides with config write");

endmodule

// File: verilog/rx_frame_checker.sv
// Receive frame buffer with XOR checksum check, forwarding good frames and dropping bad ones
`timescale 1ns/1ns

module rx_frame_checker (
  input  logic                nclk,
  input  logic                nresetn,
  input  roce_pkt_pkg::word_t rx_tdata,
  input  logic                rx_tvalid,
  output logic                rx_tready,
  input  logic                rx_tlast,
  output roce_pkt_pkg::word_t frm_tdata,
  output logic                frm_tvalid,
  input  logic                frm_tready,
  output logic                frm_tlast,
  output logic                crc_drop
);

  typedef logic [roce_pkt_pkg::BUF_AW-1:0] ptr_t;
  typedef enum logic {S_FILL, S_SEND} state_t;

  state_t              state;
  roce_pkt_pkg::word_t mem [roce_pkt_pkg::FRAME_BUF_DEPTH];
  roce_pkt_pkg::word_t acc;
  ptr_t                cnt;
  ptr_t                len_q;
  ptr_t                rd_ptr;
  logic                ovf;
  logic                drop_q;
  logic                in_fire;
  logic                out_fire;
  logic                good;

  assign rx_tready = (state == S_FILL);
  assign in_fire   = rx_tvalid && rx_tready;
  assign out_fire  = frm_tvalid && frm_tready;

  // Checksum word equals XOR of all stored words, and at least one payload word
  assign good = !ovf && (cnt > ptr_t'(roce_pkt_pkg::HDR_WORDS)) && (acc == rx_tdata);

  assign frm_tvalid = (state == S_SEND);
  assign frm_tdata  = mem[rd_ptr];
  assign frm_tlast  = (rd_ptr == len_q - ptr_t'(1));
  assign crc_drop   = drop_q;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state  <= S_FILL;
      cnt    <= '0;
      acc    <= '0;
      ovf    <= 1'b0;
      drop_q <= 1'b0;
      rd_ptr <= '0;
      len_q  <= '0;
    end else begin
      drop_q <= 1'b0;
      if (in_fire) begin
        if (rx_tlast) begin
          cnt    <= '0;
          acc    <= '0;
          ovf    <= 1'b0;
          rd_ptr <= '0;
          len_q  <= cnt;
          if (good) begin
            state <= S_SEND;
          end else begin
            drop_q <= 1'b1;
          end
        end else begin
          acc <= acc ^ rx_tdata;
          // Frame would exceed the buffer once its checksum word arrives
          if (cnt == ptr_t'(roce_pkt_pkg::FRAME_BUF_DEPTH - 1)) begin
            ovf <= 1'b1;
          end else begin
            cnt <= cnt + ptr_t'(1);
          end
        end
      end
      if (out_fire) begin
        if (frm_tlast) begin
          state <= S_FILL;
        end else begin
          rd_ptr <= rd_ptr + ptr_t'(1);
        end
      end
    end
  end

  // Checksum word itself is never stored
  always_ff @(posedge nclk) begin
    if (in_fire && !rx_tlast && !ovf) begin
      mem[cnt] <= rx_tdata;
    end
  end

  // Forwarding only starts right after a frame's last word came in
  assert property (@(posedge nclk) disable iff (!nresetn)
    $rose(frm_tvalid) |-> $past(in_fire && rx_tlast))
    else $error("rx_frame_checker: frame released while still arriving");

endmodule

// File: verilog/rdma_rx_engine.sv
// Receive engine: header parse, PSN check, memory write issue and ack generation
`timescale 1ns/1ns

module rdma_rx_engine (
  input  logic                nclk,
  input  logic                nresetn,
  input  roce_pkt_pkg::word_t frm_tdata,
  input  logic                frm_tvalid,
  output logic                frm_tready,
  input  logic                frm_tlast,
  output rdma_pkg::qpn_t      rx_qpn,
  input  rdma_pkg::psn_t      rx_epsn,
  output logic                rx_advance,
  output logic                wr_req_valid,
  input  logic                wr_req_ready,
  output rdma_pkg::vaddr_t    wr_req_vaddr,
  output rdma_pkg::len_t      wr_req_len,
  output roce_pkt_pkg::word_t wr_data_tdata,
  output logic                wr_data_tvalid,
  input  logic                wr_data_tready,
  output logic                wr_data_tlast,
  output logic                ack_valid,
  input  logic                ack_ready,
  output rdma_pkg::qpn_t      ack_qpn,
  output rdma_pkg::psn_t      ack_psn,
  output logic                ack_is_nak,
  output logic                psn_drop,
  output logic                rx_done
);

  typedef enum logic [2:0] {S_HDR0, S_HDR1, S_WREQ, S_DATA, S_DROP, S_ACK} state_t;

  state_t           state;
  rdma_pkg::qpn_t   qpn_q;
  rdma_pkg::psn_t   psn_q;
  rdma_pkg::len_t   len_q;
  rdma_pkg::vaddr_t vaddr_q;
  rdma_pkg::psn_t   ack_psn_q;
  logic             nak_q;
  logic             frm_fire;
  logic             hdr1_fire;
  logic             psn_ok;

  assign frm_fire  = frm_tvalid && frm_tready;
  assign hdr1_fire = (state == S_HDR1) && frm_fire;
  assign psn_ok    = (psn_q == rx_epsn);

  // Headers and dropped frames are consumed freely, payload follows wr_data
  assign frm_tready = (state == S_DATA) ? wr_data_tready :
                      (state == S_HDR0 || state == S_HDR1 || state == S_DROP);

  assign rx_qpn = qpn_q;

  assign wr_req_valid = (state == S_WREQ);
  assign wr_req_vaddr = vaddr_q;
  assign wr_req_len   = len_q;

  assign wr_data_tvalid = (state == S_DATA) && frm_tvalid;
  assign wr_data_tdata  = frm_tdata;
  assign wr_data_tlast  = frm_tlast;

  assign ack_valid  = (state == S_ACK);
  assign ack_qpn    = qpn_q;
  assign ack_psn    = ack_psn_q;
  assign ack_is_nak = nak_q;

  assign rx_advance = (state == S_DATA) && frm_fire && frm_tlast;
  assign rx_done    = rx_advance;
  assign psn_drop   = hdr1_fire && !psn_ok;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state <= S_HDR0;
    end else begin
      case (state)
        S_HDR0: if (frm_fire) state <= S_HDR1;
        S_HDR1: if (frm_fire) state <= psn_ok ? S_WREQ : S_DROP;
        S_WREQ: if (wr_req_ready) state <= S_DATA;
        S_DATA, S_DROP: if (frm_fire && frm_tlast) state <= S_ACK;
        S_ACK: if (ack_ready) state <= S_HDR0;
        default: state <= S_HDR0;
      endcase
    end
  end

  // Word 0 is {qpn, psn, len}, word 1 the remote address
  always_ff @(posedge nclk) begin
    if (state == S_HDR0 && frm_fire) begin
      qpn_q <= frm_tdata[31:24];
      psn_q <= frm_tdata[23:8];
      len_q <= frm_tdata[7:0];
    end
    // Ack PSN is the expected one, equal to the received one on a match
    if (hdr1_fire) begin
      vaddr_q   <= frm_tdata;
      ack_psn_q <= rx_epsn;
      nak_q     <= !psn_ok;
    end
  end

  assert property (@(posedge nclk) disable iff (!nresetn)
    wr_req_valid && !wr_req_ready |=>
      wr_req_valid && $stable(wr_req_vaddr) && $stable(wr_req_len))
    else $error("rdma_rx_engine: wr_req changed while stalled");

  assert property (@(posedge nclk) disable iff (!nresetn)
    ack_valid && !ack_ready |=> ack_valid && $stable({ack_qpn, ack_psn, ack_is_nak}))
    else $error("rdma_rx_engine: ack changed while stalled");

endmodule

// File: verilog/rdma_tx_engine.sv
// Transmit engine: send-queue command, memory read and checksummed frame output
`timescale 1ns/1ns

module rdma_tx_engine (
  input  logic                nclk,
  input  logic                nresetn,
  input  logic                sq_valid,
  output logic                sq_ready,
  input  rdma_pkg::qpn_t      sq_qpn,
  input  rdma_pkg::vaddr_t    sq_local_vaddr,
  input  rdma_pkg::vaddr_t    sq_remote_vaddr,
  input  rdma_pkg::len_t      sq_len,
  output logic                rd_req_valid,
  input  logic                rd_req_ready,
  output rdma_pkg::vaddr_t    rd_req_vaddr,
  output rdma_pkg::len_t      rd_req_len,
  input  roce_pkt_pkg::word_t rd_data_tdata,
  input  logic                rd_data_tvalid,
  output logic                rd_data_tready,
  input  logic                rd_data_tlast,
  output rdma_pkg::qpn_t      tx_qpn,
  input  rdma_pkg::psn_t      tx_psn,
  output logic                tx_advance,
  output roce_pkt_pkg::word_t tx_tdata,
  output logic                tx_tvalid,
  input  logic                tx_tready,
  output logic                tx_tlast,
  output logic                tx_done
);

  typedef enum logic [2:0] {S_IDLE, S_RREQ, S_HDR0, S_HDR1, S_DATA, S_CSUM} state_t;

  state_t              state;
  rdma_pkg::qpn_t      qpn_q;
  rdma_pkg::vaddr_t    lvaddr_q;
  rdma_pkg::vaddr_t    rvaddr_q;
  rdma_pkg::len_t      len_q;
  rdma_pkg::len_t      cnt_q;
  roce_pkt_pkg::word_t csum_q;
  logic                tx_fire;
  logic                data_last;

  assign sq_ready = (state == S_IDLE);

  assign rd_req_valid   = (state == S_RREQ);
  assign rd_req_vaddr   = lvaddr_q;
  assign rd_req_len     = len_q;
  assign rd_data_tready = (state == S_DATA) && tx_tready;

  assign tx_qpn = qpn_q;

  always_comb begin
    case (state)
      S_HDR0:  tx_tdata = {qpn_q, tx_psn, len_q};
      S_HDR1:  tx_tdata = rvaddr_q;
      S_CSUM:  tx_tdata = csum_q;
      default: tx_tdata = rd_data_tdata;
    endcase
  end

  assign tx_tvalid = (state == S_HDR0) || (state == S_HDR1) || (state == S_CSUM) ||
                     ((state == S_DATA) && rd_data_tvalid);
  assign tx_tlast  = (state == S_CSUM);
  assign tx_fire   = tx_tvalid && tx_tready;
  assign data_last = (cnt_q == len_q - rdma_pkg::len_t'(1));

  assign tx_advance = tx_fire && tx_tlast;
  assign tx_done    = tx_advance;

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: if (sq_valid) state <= S_RREQ;
        S_RREQ: if (rd_req_ready) state <= S_HDR0;
        S_HDR0: if (tx_tready) state <= S_HDR1;
        S_HDR1: if (tx_tready) state <= S_DATA;
        S_DATA: if (tx_fire && data_last) state <= S_CSUM;
        S_CSUM: if (tx_tready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge nclk) begin
    if (sq_valid && sq_ready) begin
      qpn_q    <= sq_qpn;
      lvaddr_q <= sq_local_vaddr;
      rvaddr_q <= sq_remote_vaddr;
      len_q    <= sq_len;
      csum_q   <= '0;
      cnt_q    <= '0;
    end
    // Running XOR over header and payload words
    if (tx_fire && !tx_tlast) begin
      csum_q <= csum_q ^ tx_tdata;
    end
    if (state == S_DATA && tx_fire) begin
      cnt_q <= cnt_q + rdma_pkg::len_t'(1);
    end
  end

  // Memory must end the read stream exactly at the requested length
  assert property (@(posedge nclk) disable iff (!nresetn)
    rd_data_tvalid && rd_data_tready |-> rd_data_tlast == data_last)
    else $error("rdma_tx_engine: read data tlast disagrees with length");

  assert property (@(posedge nclk) disable iff (!nresetn)
    sq_valid && sq_ready |-> sq_len != 0 && sq_len <= rdma_pkg::MAX_LEN)
    else $error("rdma_tx_engine: send length out of range");

endmodule

// File: verilog/roce_stack.sv
// RoCE stack top: engines, QP PSN table and packet counters
`timescale 1ns/1ns

module roce_stack (
  input  logic                nclk,
  input  logic                nresetn,
  // Network streams
  input  roce_pkt_pkg::word_t rx_tdata,
  input  logic                rx_tvalid,
  output logic                rx_tready,
  input  logic                rx_tlast,
  output roce_pkt_pkg::word_t tx_tdata,
  output logic                tx_tvalid,
  input  logic                tx_tready,
  output logic                tx_tlast,
  // Send queue
  input  logic                sq_valid,
  output logic                sq_ready,
  input  rdma_pkg::qpn_t      sq_qpn,
  input  rdma_pkg::vaddr_t    sq_local_vaddr,
  input  rdma_pkg::vaddr_t    sq_remote_vaddr,
  input  rdma_pkg::len_t      sq_len,
  // Memory read
  output logic                rd_req_valid,
  input  logic                rd_req_ready,
  output rdma_pkg::vaddr_t    rd_req_vaddr,
  output rdma_pkg::len_t      rd_req_len,
  input  roce_pkt_pkg::word_t rd_data_tdata,
  input  logic                rd_data_tvalid,
  output logic                rd_data_tready,
  input  logic                rd_data_tlast,
  // Memory write
  output logic                wr_req_valid,
  input  logic                wr_req_ready,
  output rdma_pkg::vaddr_t    wr_req_vaddr,
  output rdma_pkg::len_t      wr_req_len,
  output roce_pkt_pkg::word_t wr_data_tdata,
  output logic                wr_data_tvalid,
  input  logic                wr_data_tready,
  output logic                wr_data_tlast,
  // Acks
  output logic                ack_valid,
  input  logic                ack_ready,
  output rdma_pkg::qpn_t      ack_qpn,
  output rdma_pkg::psn_t      ack_psn,
  output logic                ack_is_nak,
  // QP setup
  input  logic                qp_cfg_valid,
  input  rdma_pkg::qpn_t      qp_cfg_qpn,
  input  rdma_pkg::psn_t      qp_cfg_psn,
  // Counters
  output logic [31:0]         rx_pkt_count,
  output logic [31:0]         tx_pkt_count,
  output logic [31:0]         crc_drop_count,
  output logic [31:0]         psn_drop_count
);

  roce_pkt_pkg::word_t frm_tdata;
  logic                frm_tvalid;
  logic                frm_tready;
  logic                frm_tlast;
  rdma_pkg::qpn_t      tbl_tx_qpn;
  rdma_pkg::psn_t      tbl_tx_psn;
  logic                tbl_tx_advance;
  rdma_pkg::qpn_t      tbl_rx_qpn;
  rdma_pkg::psn_t      tbl_rx_epsn;
  logic                tbl_rx_advance;
  logic                crc_drop;
  logic                psn_drop;
  logic                rx_done;
  logic                tx_done;

  qp_psn_table u_qp_table (
    .nclk       (nclk),
    .nresetn    (nresetn),
    .cfg_valid  (qp_cfg_valid),
    .cfg_qpn    (qp_cfg_qpn),
    .cfg_psn    (qp_cfg_psn),
    .tx_qpn     (tbl_tx_qpn),
    .tx_psn     (tbl_tx_psn),
    .tx_advance (tbl_tx_advance),
    .rx_qpn     (tbl_rx_qpn),
    .rx_epsn    (tbl_rx_epsn),
    .rx_advance (tbl_rx_advance)
  );

  rx_frame_checker u_rx_check (
    .nclk       (nclk),
    .nresetn    (nresetn),
    .rx_tdata   (rx_tdata),
    .rx_tvalid  (rx_tvalid),
    .rx_tready  (rx_tready),
    .rx_tlast   (rx_tlast),
    .frm_tdata  (frm_tdata),
    .frm_tvalid (frm_tvalid),
    .frm_tready (frm_tready),
    .frm_tlast  (frm_tlast),
    .crc_drop   (crc_drop)
  );

  rdma_rx_engine u_rx_engine (
    .nclk           (nclk),
    .nresetn        (nresetn),
    .frm_tdata      (frm_tdata),
    .frm_tvalid     (frm_tvalid),
    .frm_tready     (frm_tready),
    .frm_tlast      (frm_tlast),
    .rx_qpn         (tbl_rx_qpn),
    .rx_epsn        (tbl_rx_epsn),
    .rx_advance     (tbl_rx_advance),
    .wr_req_valid   (wr_req_valid),
    .wr_req_ready   (wr_req_ready),
    .wr_req_vaddr   (wr_req_vaddr),
    .wr_req_len     (wr_req_len),
    .wr_data_tdata  (wr_data_tdata),
    .wr_data_tvalid (wr_data_tvalid),
    .wr_data_tready (wr_data_tready),
    .wr_data_tlast  (wr_data_tlast),
    .ack_valid      (ack_valid),
    .ack_ready      (ack_ready),
    .ack_qpn        (ack_qpn),
    .ack_psn        (ack_psn),
    .ack_is_nak     (ack_is_nak),
    .psn_drop       (psn_drop),
    .rx_done        (rx_done)
  );

  rdma_tx_engine u_tx_engine (
    .nclk            (nclk),
    .nresetn         (nresetn),
    .sq_valid        (sq_valid),
    .sq_ready        (sq_ready),
    .sq_qpn          (sq_qpn),
    .sq_local_vaddr  (sq_local_vaddr),
    .sq_remote_vaddr (sq_remote_vaddr),
    .sq_len          (sq_len),
    .rd_req_valid    (rd_req_valid),
    .rd_req_ready    (rd_req_ready),
    .rd_req_vaddr    (rd_req_vaddr),
    .rd_req_len      (rd_req_len),
    .rd_data_tdata   (rd_data_tdata),
    .rd_data_tvalid  (rd_data_tvalid),
    .rd_data_tready  (rd_data_tready),
    .rd_data_tlast   (rd_data_tlast),
    .tx_qpn          (tbl_tx_qpn),
    .tx_psn          (tbl_tx_psn),
    .tx_advance      (tbl_tx_advance),
    .tx_tdata        (tx_tdata),
    .tx_tvalid       (tx_tvalid),
    .tx_tready       (tx_tready),
    .tx_tlast        (tx_tlast),
    .tx_done         (tx_done)
  );

  // Packet counters, one count per engine pulse
  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      rx_pkt_count   <= '0;
      tx_pkt_count   <= '0;
      crc_drop_count <= '0;
      psn_drop_count <= '0;
    end else begin
      if (rx_done) begin
        rx_pkt_count <= rx_pkt_count + 32'd1;
      end
      if (tx_done) begin
        tx_pkt_count <= tx_pkt_count + 32'd1;
      end
      if (crc_drop) begin
        crc_drop_count <= crc_drop_count + 32'd1;
      end
      if (psn_drop) begin
        psn_drop_count <= psn_drop_count + 32'd1;
      end
    end
  end

endmodule

// File: verif/roce_stack_tb.sv
// Directed testbench for the RoCE stack: clock, reset, xorshift stimulus, test tasks, error summary
`timescale 1ns/1ns

module roce_stack_tb;

  localparam int TIMEOUT = 400;
  localparam int QUIET_CYCLES = 60;

  logic                nclk;
  logic                nresetn;
  roce_pkt_pkg::word_t rx_tdata;
  logic                rx_tvalid;
  logic                rx_tready;
  logic                rx_tlast;
  roce_pkt_pkg::word_t tx_tdata;
  logic                tx_tvalid;
  logic                tx_tready;
  logic                tx_tlast;
  logic                sq_valid;
  logic                sq_ready;
  rdma_pkg::qpn_t      sq_qpn;
  rdma_pkg::vaddr_t    sq_local_vaddr;
  rdma_pkg::vaddr_t    sq_remote_vaddr;
  rdma_pkg::len_t      sq_len;
  logic                rd_req_valid;
  logic                rd_req_ready;
  rdma_pkg::vaddr_t    rd_req_vaddr;
  rdma_pkg::len_t      rd_req_len;
  roce_pkt_pkg::word_t rd_data_tdata;
  logic                rd_data_tvalid;
  logic                rd_data_tready;
  logic                rd_data_tlast;
  logic                wr_req_valid;
  logic                wr_req_ready;
  rdma_pkg::vaddr_t    wr_req_vaddr;
  rdma_pkg::len_t      wr_req_len;
  roce_pkt_pkg::word_t wr_data_tdata;
  logic                wr_data_tvalid;
  logic                wr_data_tready;
  logic                wr_data_tlast;
  logic                ack_valid;
  logic                ack_ready;
  rdma_pkg::qpn_t      ack_qpn;
  rdma_pkg::psn_t      ack_psn;
  logic                ack_is_nak;
  logic                qp_cfg_valid;
  rdma_pkg::qpn_t      qp_cfg_qpn;
  rdma_pkg::psn_t      qp_cfg_psn;
  logic [31:0]         rx_pkt_count;
  logic [31:0]         tx_pkt_count;
  logic [31:0]         crc_drop_count;
  logic [31:0]         psn_drop_count;

  int                  mismatches;
  int                  timeouts;
  int                  exp_rx;
  int                  exp_tx;
  int                  exp_crc;
  int                  exp_psn_drop;
  logic [31:0]         rng;
  roce_pkt_pkg::word_t pay [rdma_pkg::MAX_LEN];
  roce_pkt_pkg::word_t got_q [$];
  // Reference PSN state, per QP
  rdma_pkg::psn_t      tx_psn_m [rdma_pkg::N_QP];
  rdma_pkg::psn_t      rx_psn_m [rdma_pkg::N_QP];

  roce_stack dut (.*);

  initial begin
    nclk = 1'b0;
    forever #50 nclk = ~nclk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Ready high about three cycles in four when stalling
  function automatic logic pick_ready(input logic stall);
    logic r;
    r = 1'b1;
    if (stall) begin
      r = (next_rand() & 32'h3) != 0;
    end
    return r;
  endfunction

  function automatic int qp_index(input rdma_pkg::qpn_t qpn);
    return int'(qpn[rdma_pkg::QP_IDX_BITS-1:0]);
  endfunction

  task automatic report_mismatch(input string msg);
    mismatches++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
  endtask

  task automatic check_counts();
    if (rx_pkt_count != exp_rx)
      report_mismatch($sformatf("rx_pkt_count %0d, expected %0d", rx_pkt_count, exp_rx));
    if (tx_pkt_count != exp_tx)
      report_mismatch($sformatf("tx_pkt_count %0d, expected %0d", tx_pkt_count, exp_tx));
    if (crc_drop_count != exp_crc)
      report_mismatch($sformatf("crc_drop_count %0d, expected %0d", crc_drop_count, exp_crc));
    if (psn_drop_count != exp_psn_drop)
      report_mismatch($sformatf("psn_drop_count %0d, expected %0d", psn_drop_count,
                                exp_psn_drop));
  endtask

  task automatic check_reset_state();
    if (tx_tvalid || rd_req_valid || wr_req_valid || wr_data_tvalid || ack_valid)
      report_mismatch("a valid output is high after reset");
    if (!sq_ready || !rx_tready)
      report_mismatch("sq_ready or rx_tready is low after reset");
    check_counts();
  endtask

  task automatic fill_payload(input int len);
    for (int i = 0; i < len; i++) begin
      pay[i] = next_rand();
    end
  endtask

  task automatic configure_qp(input rdma_pkg::qpn_t qpn, input rdma_pkg::psn_t psn);
    qp_cfg_valid = 1'b1;
    qp_cfg_qpn   = qpn;
    qp_cfg_psn   = psn;
    @(negedge nclk);
    qp_cfg_valid = 1'b0;
    tx_psn_m[qp_index(qpn)] = psn;
    rx_psn_m[qp_index(qpn)] = psn;
  endtask

  // Posts one write, plays the memory side and checks the transmitted frame
  task automatic post_write(input rdma_pkg::qpn_t qpn, input rdma_pkg::vaddr_t lvaddr,
                            input rdma_pkg::vaddr_t rvaddr, input int len, input logic stall);
    int                  n;
    int                  idx;
    logic                got;
    logic                req_seen;
    logic                done;
    roce_pkt_pkg::word_t exp_w;
    roce_pkt_pkg::word_t csum;
    got = 1'b0;
    n = 0;
    sq_valid        = 1'b1;
    sq_qpn          = qpn;
    sq_local_vaddr  = lvaddr;
    sq_remote_vaddr = rvaddr;
    sq_len          = rdma_pkg::len_t'(len);
    while (!got && n < TIMEOUT) begin
      #1;
      if (sq_ready) got = 1'b1;
      @(negedge nclk);
      n++;
    end
    sq_valid = 1'b0;
    if (!got) report_timeout("sq_ready");
    got_q.delete();
    idx = 0;
    req_seen = 1'b0;
    done = 1'b0;
    n = 0;
    while (!done && n < TIMEOUT) begin
      rd_req_ready   = pick_ready(stall);
      rd_data_tvalid = req_seen && (idx < len);
      rd_data_tdata  = (idx < len) ? pay[idx] : '0;
      rd_data_tlast  = (idx == len - 1);
      tx_tready      = pick_ready(stall);
      #1;
      if (rd_req_valid && rd_req_ready) begin
        req_seen = 1'b1;
        if (rd_req_vaddr != lvaddr || rd_req_len != rdma_pkg::len_t'(len))
          report_mismatch($sformatf("rd_req %h/%0d, expected %h/%0d", rd_req_vaddr,
                                    rd_req_len, lvaddr, len));
      end
      if (rd_data_tvalid && rd_data_tready) idx++;
      if (tx_tvalid && tx_tready) begin
        got_q.push_back(tx_tdata);
        if (tx_tlast) done = 1'b1;
      end
      @(negedge nclk);
      n++;
    end
    rd_req_ready   = 1'b0;
    rd_data_tvalid = 1'b0;
    rd_data_tlast  = 1'b0;
    tx_tready      = 1'b1;
    if (!done) report_timeout("tx_tlast");
    // Header, remote address, payload, then XOR of all of them
    if (got_q.size() != len + 3) begin
      report_mismatch($sformatf("tx frame has %0d words, expected %0d", got_q.size(), len + 3));
    end else begin
      csum = '0;
      for (int k = 0; k < len + 2; k++) begin
        if (k == 0) exp_w = {qpn, tx_psn_m[qp_index(qpn)], rdma_pkg::len_t'(len)};
        else if (k == 1) exp_w = rvaddr;
        else exp_w = pay[k-2];
        if (got_q[k] != exp_w)
          report_mismatch($sformatf("tx word %0d is %h, expected %h", k, got_q[k], exp_w));
        csum = csum ^ exp_w;
      end
      if (got_q[len+2] != csum)
        report_mismatch($sformatf("tx checksum %h, expected %h", got_q[len+2], csum));
    end
    tx_psn_m[qp_index(qpn)]++;
    exp_tx++;
    @(negedge nclk);
    check_counts();
  endtask

  task automatic send_frame(input rdma_pkg::qpn_t qpn, input rdma_pkg::psn_t psn,
                            input rdma_pkg::vaddr_t vaddr, input int len, input logic corrupt);
    roce_pkt_pkg::word_t frame [$];
    roce_pkt_pkg::word_t csum;
    int                  i;
    int                  n;
    frame.push_back({qpn, psn, rdma_pkg::len_t'(len)});
    frame.push_back(vaddr);
    for (int k = 0; k < len; k++) begin
      frame.push_back(pay[k]);
    end
    csum = '0;
    foreach (frame[k]) csum = csum ^ frame[k];
    // Single flipped bit spoils the checksum
    if (corrupt) csum = csum ^ 32'h0000_0100;
    frame.push_back(csum);
    i = 0;
    n = 0;
    while (i < frame.size() && n < TIMEOUT) begin
      rx_tvalid = 1'b1;
      rx_tdata  = frame[i];
      rx_tlast  = (i == frame.size() - 1);
      #1;
      if (rx_tready) i++;
      @(negedge nclk);
      n++;
    end
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    if (i < frame.size()) report_timeout("rx_tready");
  endtask

  // Plays the memory and ack sides for one received frame
  task automatic check_rx_result(input rdma_pkg::qpn_t qpn, input rdma_pkg::vaddr_t vaddr,
                                 input int len, input logic nak, input logic stall);
    int             n;
    int             nreq;
    logic           done;
    rdma_pkg::psn_t exp_psn;
    exp_psn = rx_psn_m[qp_index(qpn)];
    got_q.delete();
    nreq = 0;
    done = 1'b0;
    n = 0;
    while (!done && n < TIMEOUT) begin
      wr_req_ready   = pick_ready(stall);
      wr_data_tready = pick_ready(stall);
      ack_ready      = pick_ready(stall);
      #1;
      if (wr_req_valid && wr_req_ready) begin
        nreq++;
        if (wr_req_vaddr != vaddr || wr_req_len != rdma_pkg::len_t'(len))
          report_mismatch($sformatf("wr_req %h/%0d, expected %h/%0d", wr_req_vaddr,
                                    wr_req_len, vaddr, len));
      end
      if (wr_data_tvalid && wr_data_tready) begin
        if (nreq == 0) report_mismatch("wr_data came before wr_req");
        if (wr_data_tlast != (got_q.size() == len - 1))
          report_mismatch($sformatf("wr_data_tlast wrong on word %0d", got_q.size()));
        got_q.push_back(wr_data_tdata);
      end
      if (ack_valid && ack_ready) begin
        done = 1'b1;
        if (ack_qpn != qpn || ack_psn != exp_psn || ack_is_nak != nak)
          report_mismatch($sformatf("ack %0d/%0d/%b, expected %0d/%0d/%b", ack_qpn, ack_psn,
                                    ack_is_nak, qpn, exp_psn, nak));
      end
      @(negedge nclk);
      n++;
    end
    wr_req_ready   = 1'b0;
    wr_data_tready = 1'b0;
    ack_ready      = 1'b0;
    if (!done) report_timeout("ack_valid");
    if (nak) begin
      if (nreq != 0 || got_q.size() != 0)
        report_mismatch("memory write issued for a frame with a bad PSN");
      exp_psn_drop++;
    end else begin
      if (nreq != 1)
        report_mismatch($sformatf("%0d write requests, expected 1", nreq));
      if (got_q.size() != len)
        report_mismatch($sformatf("%0d write words, expected %0d", got_q.size(), len));
      for (int k = 0; k < len && k < got_q.size(); k++) begin
        if (got_q[k] != pay[k])
          report_mismatch($sformatf("wr word %0d is %h, expected %h", k, got_q[k], pay[k]));
      end
      rx_psn_m[qp_index(qpn)]++;
      exp_rx++;
    end
    @(negedge nclk);
    check_counts();
  endtask

  // A dropped frame must leave the write and ack channels idle
  task automatic expect_quiet();
    wr_req_ready   = 1'b1;
    wr_data_tready = 1'b1;
    ack_ready      = 1'b1;
    for (int n = 0; n < QUIET_CYCLES; n++) begin
      #1;
      if (wr_req_valid || wr_data_tvalid || ack_valid)
        report_mismatch("write or ack activity for a dropped frame");
      @(negedge nclk);
    end
    wr_req_ready   = 1'b0;
    wr_data_tready = 1'b0;
    ack_ready      = 1'b0;
    exp_crc++;
    check_counts();
  endtask

  initial begin
    int len;
    nresetn         = 1'b0;
    rx_tdata        = '0;
    rx_tvalid       = 1'b0;
    rx_tlast        = 1'b0;
    tx_tready       = 1'b1;
    sq_valid        = 1'b0;
    sq_qpn          = '0;
    sq_local_vaddr  = '0;
    sq_remote_vaddr = '0;
    sq_len          = '0;
    rd_req_ready    = 1'b0;
    rd_data_tdata   = '0;
    rd_data_tvalid  = 1'b0;
    rd_data_tlast   = 1'b0;
    wr_req_ready    = 1'b0;
    wr_data_tready  = 1'b0;
    ack_ready       = 1'b0;
    qp_cfg_valid    = 1'b0;
    qp_cfg_qpn      = '0;
    qp_cfg_psn      = '0;
    rng             = 32'h92397cd0;
    mismatches      = 0;
    timeouts        = 0;
    exp_rx          = 0;
    exp_tx          = 0;
    exp_crc         = 0;
    exp_psn_drop    = 0;
    for (int q = 0; q < rdma_pkg::N_QP; q++) begin
      tx_psn_m[q] = '0;
      rx_psn_m[q] = '0;
    end
    repeat (8) @(posedge nclk);
    @(negedge nclk);
    nresetn = 1'b1;
    @(negedge nclk);
    check_reset_state();

    // Transmit path, two posts on QP 1
    configure_qp(8'd1, 16'd100);
    fill_payload(5);
    post_write(8'd1, 32'h0000_1000, 32'h8000_0040, 5, 1'b0);
    fill_payload(3);
    post_write(8'd1, 32'h0000_1100, 32'h8000_0080, 3, 1'b0);

    // Good receive frame on QP 2
    configure_qp(8'd2, 16'd7);
    fill_payload(4);
    send_frame(8'd2, rx_psn_m[2], 32'h4000_0000, 4, 1'b0);
    check_rx_result(8'd2, 32'h4000_0000, 4, 1'b0, 1'b0);

    // Bad checksum, then a good frame
    fill_payload(6);
    send_frame(8'd2, rx_psn_m[2], 32'h4000_0100, 6, 1'b1);
    expect_quiet();
    fill_payload(2);
    send_frame(8'd2, rx_psn_m[2], 32'h4000_0200, 2, 1'b0);
    check_rx_result(8'd2, 32'h4000_0200, 2, 1'b0, 1'b0);

    // Out-of-order PSN gets a NAK, the expected PSN then succeeds
    configure_qp(8'd3, 16'd20);
    fill_payload(3);
    send_frame(8'd3, 16'd25, 32'h5000_0000, 3, 1'b0);
    check_rx_result(8'd3, 32'h5000_0000, 3, 1'b1, 1'b0);
    send_frame(8'd3, rx_psn_m[3], 32'h5000_0000, 3, 1'b0);
    check_rx_result(8'd3, 32'h5000_0000, 3, 1'b0, 1'b0);

    // Both directions again under random back-pressure
    for (int r = 0; r < 3; r++) begin
      len = int'(next_rand() % 16) + 1;
      fill_payload(len);
      post_write(8'd1, 32'h0000_2000 + r * 32'h100, 32'h8000_1000 + r * 32'h40, len, 1'b1);
      len = int'(next_rand() % 16) + 1;
      fill_payload(len);
      send_frame(8'd2, rx_psn_m[2], 32'h4000_1000 + r * 32'h100, len, 1'b0);
      check_rx_result(8'd2, 32'h4000_1000 + r * 32'h100, len, 1'b0, 1'b1);
    end

    $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: project.f
verilog/rdma_pkg.sv
verilog/roce_pkt_pkg.sv
verilog/qp_psn_table.sv
verilog/rx_frame_checker.sv
verilog/rdma_rx_engine.sv
verilog/rdma_tx_engine.sv
verilog/roce_stack.sv
verif/roce_stack_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module roce_stack_tb -f project.f

out=$(./obj_dir/Vroce_stack_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
